//--- all.f
+incdir+common
common/zmips_pkg.sv
common/exe_bus_if.sv
design/regfile.sv
design/execute/alu.sv
design/execute/exec_stage.sv
design/fetch_decode.sv
design/zmips_top.sv
sim/tb_memory.sv
sim/tb_zmips.sv

//--- common/exe_bus_if.sv
/*
  Decode to execute bus, no handshake
  A bubble is valid low with every write enable low
  Writeback and hazard fields flow back from execute
*/
`include "zmips_consts.svh"

interface exe_bus_if;
    import zmips_pkg::*;

    // Issued by decode at the ID/EX edge
    logic [`ZM_RADDR-1:0] rs;
    logic [`ZM_RADDR-1:0] rt;
    logic [`ZM_RADDR-1:0] rd;        // Forced to 0 for load immediate
    logic [`ZM_XLEN-1:0]  rs_val;
    logic [`ZM_XLEN-1:0]  rt_val;
    logic [`ZM_XLEN-1:0]  imm;       // Sign extended, low bits carry shamt
    alu_op_e              alu_op;
    logic                 use_imm;   // ALU b from imm instead of rt
    logic                 mem_rd;
    logic                 mem_wr;
    logic                 wr_reg;
    flags_t               flag_en;   // Per-flag update enables
    logic                 valid;

    // Returned by execute
    flags_t               live_flags;   // Flags including the instruction in EX
    logic [`ZM_RADDR-1:0] ex_load_rd;
    logic                 ex_is_load;
    logic                 wb_wr;
    logic [`ZM_RADDR-1:0] wb_addr;
    logic [`ZM_XLEN-1:0]  wb_data;

    modport decode (
        output rs, rt, rd, rs_val, rt_val, imm, alu_op, use_imm,
        output mem_rd, mem_wr, wr_reg, flag_en, valid,
        input  live_flags, ex_load_rd, ex_is_load, wb_wr, wb_addr, wb_data
    );

    modport execute (
        input  rs, rt, rd, rs_val, rt_val, imm, alu_op, use_imm,
        input  mem_rd, mem_wr, wr_reg, flag_en, valid,
        output live_flags, ex_load_rd, ex_is_load, wb_wr, wb_addr, wb_data
    );
endinterface

//--- common/zmips_consts.svh
/*
  Core-wide widths and the reset vector
  The instruction field positions are fixed by the encoding and are not parameters
  Changing ZM_XLEN alone does not resize the instruction word
*/
`ifndef ZMIPS_CONSTS_SVH
`define ZMIPS_CONSTS_SVH

// Datapath and address width
`define ZM_XLEN 32

// Register number width and register count
`define ZM_RADDR 5
`define ZM_NREGS 32

// Sign-extended immediate field, bits 25:0
`define ZM_IMM_W 26

// Absolute jump field, bits 29:0, a word address
`define ZM_JADDR_W 30

`define ZM_PC_STEP 4      // Byte step between instructions
`define ZM_RESET_PC 0     // First fetch address

`endif

//--- common/zmips_pkg.sv
/*
  Shared types for the pipelined core
  Encodings follow the instruction word layout, so enum values must not be reordered
*/
package zmips_pkg;

    // Instruction format, bits 31:30
    typedef enum logic [1:0] {
        FMT_R      = 2'b00,   // Register ALU, load, store
        FMT_LIMM   = 2'b01,   // Sign-extended load immediate into r0
        FMT_BRANCH = 2'b10,   // PC relative, flag conditional
        FMT_JUMP   = 2'b11    // Absolute word address
    } fmt_e;

    // ALU operation, {op[26], funct[5:3]}
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SUB    = 4'b0001,  // Also used as compare with no writeback
        ALU_AND    = 4'b0010,
        ALU_OR     = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_NOR    = 4'b0101,
        ALU_PASS_A = 4'b0110,
        ALU_PASS_B = 4'b0111,
        ALU_SLL    = 4'b1000,  // Shift group, rs by shamt
        ALU_SRL    = 4'b1001,
        ALU_SRA    = 4'b1010
    } alu_op_e;

    // Branch condition, bits 27:26
    typedef enum logic [1:0] {
        COND_Z      = 2'b00,
        COND_C      = 2'b01,
        COND_N      = 2'b10,
        COND_ALWAYS = 2'b11
    } cond_e;

    // Status flags, also reused as per-flag update enables
    typedef struct packed {
        logic z;
        logic c;
        logic n;
    } flags_t;

endpackage

//--- design/execute/alu.sv
/*
  Combinational ALU
  carry is the carry-out on ADD and no-borrow on SUB, 0 otherwise
  Shifts act on a by shamt, b is ignored
  Unused op codes return 0
*/
`include "zmips_consts.svh"

module alu (
    input  logic [`ZM_XLEN-1:0] a,
    input  logic [`ZM_XLEN-1:0] b,
    input  zmips_pkg::alu_op_e  op,
    input  logic [4:0]          shamt,
    output logic [`ZM_XLEN-1:0] y,
    output logic                zero,
    output logic                carry
);
    import zmips_pkg::*;

    always_comb
    begin
        carry = 1'b0;
        case (op)
            ALU_ADD:    {carry, y} = {1'b0, a} + {1'b0, b};
            ALU_SUB:    {carry, y} = {1'b0, a} + {1'b0, ~b} + (`ZM_XLEN+1)'(1);   // a + ~b + 1
            ALU_AND:    y = a & b;
            ALU_OR:     y = a | b;
            ALU_XOR:    y = a ^ b;
            ALU_NOR:    y = ~(a | b);
            ALU_PASS_A: y = a;
            ALU_PASS_B: y = b;          // Load immediate path
            ALU_SLL:    y = a << shamt;
            ALU_SRL:    y = a >> shamt;
            ALU_SRA:    y = $signed(a) >>> shamt;
            default:    y = '0;
        endcase
    end

    assign zero = (y == '0);

endmodule

//--- design/execute/exec_stage.sv
/*
  Execute, memory and writeback stages
  Operand priority is EX/MEM result, then MEM/WB value, then the register file
  A load result in EX/MEM is never forwarded, decode stalls that case
  Data memory answers combinationally, loaded data is captured in MEM/WB
*/
`include "zmips_consts.svh"

module exec_stage (
    input  logic                clk,
    input  logic                rst,
    exe_bus_if.execute          bus,
    output logic [`ZM_XLEN-1:0] d_addr,
    output logic [`ZM_XLEN-1:0] d_data_o,
    output logic                d_wr,
    output logic                d_rd,
    input  logic [`ZM_XLEN-1:0] d_data_i
);
    import zmips_pkg::*;

    // ID/EX
    logic                 idex_valid;
    logic [`ZM_RADDR-1:0] idex_rs;
    logic [`ZM_RADDR-1:0] idex_rt;
    logic [`ZM_RADDR-1:0] idex_rd;
    logic [`ZM_XLEN-1:0]  idex_rs_val;
    logic [`ZM_XLEN-1:0]  idex_rt_val;
    logic [`ZM_XLEN-1:0]  idex_imm;
    alu_op_e              idex_op;
    logic                 idex_use_imm;
    logic                 idex_mem_rd;
    logic                 idex_mem_wr;
    logic                 idex_wr_reg;
    flags_t               idex_flag_en;

    // EX/MEM
    logic [`ZM_XLEN-1:0]  exmem_res;      // Also the memory address
    logic [`ZM_XLEN-1:0]  exmem_data;     // Store data
    logic [`ZM_RADDR-1:0] exmem_rd;
    logic [`ZM_RADDR-1:0] exmem_rt;
    logic                 exmem_mem_rd;
    logic                 exmem_mem_wr;
    logic                 exmem_wr_reg;

    // MEM/WB
    logic [`ZM_XLEN-1:0]  memwb_mdata;
    logic [`ZM_XLEN-1:0]  memwb_res;
    logic [`ZM_RADDR-1:0] memwb_rd;
    logic                 memwb_mem_rd;
    logic                 memwb_wr_reg;

    logic [`ZM_XLEN-1:0]  wb_data;
    logic [`ZM_XLEN-1:0]  op_a;
    logic [`ZM_XLEN-1:0]  op_b;
    logic [`ZM_XLEN-1:0]  alu_y;
    logic                 alu_zero;
    logic                 alu_carry;
    flags_t               flags;
    flags_t               flags_nxt;

    always_ff @(posedge clk)
    begin
        idex_rs      <= bus.rs;
        idex_rt      <= bus.rt;
        idex_rd      <= bus.rd;
        idex_rs_val  <= bus.rs_val;
        idex_rt_val  <= bus.rt_val;
        idex_imm     <= bus.imm;
        idex_op      <= bus.alu_op;
        idex_use_imm <= bus.use_imm;
        if (rst)
        begin
            idex_valid   <= 1'b0;
            idex_mem_rd  <= 1'b0;
            idex_mem_wr  <= 1'b0;
            idex_wr_reg  <= 1'b0;
            idex_flag_en <= '0;
        end
        else
        begin
            idex_valid   <= bus.valid;
            idex_mem_rd  <= bus.mem_rd;
            idex_mem_wr  <= bus.mem_wr;
            idex_wr_reg  <= bus.wr_reg;
            idex_flag_en <= bus.flag_en;
        end
    end

    // Operand forwarding, newest producer wins
    always_comb
    begin
        if (exmem_wr_reg && exmem_rd == idex_rs)
            op_a = exmem_res;
        else if (memwb_wr_reg && memwb_rd == idex_rs)
            op_a = wb_data;
        else
            op_a = idex_rs_val;

        if (exmem_wr_reg && exmem_rd == idex_rt)
            op_b = exmem_res;
        else if (memwb_wr_reg && memwb_rd == idex_rt)
            op_b = wb_data;
        else
            op_b = idex_rt_val;
    end

    alu u_alu (
        .a     (op_a),
        .b     (idex_use_imm ? idex_imm : op_b),
        .op    (idex_op),
        .shamt (idex_imm[10:6]),   // shamt field rides in the immediate
        .y     (alu_y),
        .zero  (alu_zero),
        .carry (alu_carry)
    );

    // Selective flag update, seen by the branch in ID this same cycle
    assign flags_nxt.z = (idex_valid && idex_flag_en.z) ? alu_zero : flags.z;
    assign flags_nxt.c = (idex_valid && idex_flag_en.c) ? alu_carry : flags.c;
    assign flags_nxt.n = (idex_valid && idex_flag_en.n) ? alu_y[`ZM_XLEN-1] : flags.n;

    always_ff @(posedge clk)
    begin
        if (rst)
            flags <= '0;
        else
            flags <= flags_nxt;
    end

    always_ff @(posedge clk)
    begin
        exmem_res  <= alu_y;
        exmem_data <= op_b;
        exmem_rd   <= idex_rd;
        exmem_rt   <= idex_rt;
        if (rst)
        begin
            exmem_mem_rd <= 1'b0;
            exmem_mem_wr <= 1'b0;
            exmem_wr_reg <= 1'b0;
        end
        else
        begin
            exmem_mem_rd <= idex_mem_rd;
            exmem_mem_wr <= idex_mem_wr;
            exmem_wr_reg <= idex_wr_reg;
        end
    end

    // Data memory port
    assign d_addr = exmem_res;
    assign d_wr   = exmem_mem_wr;
    assign d_rd   = exmem_mem_rd;

    // Store right behind a load of its data register takes the loaded word
    assign d_data_o = (exmem_mem_wr && memwb_mem_rd && memwb_wr_reg && memwb_rd == exmem_rt)
                      ? memwb_mdata : exmem_data;

    always_ff @(posedge clk)
    begin
        memwb_mdata <= d_data_i;
        memwb_res   <= exmem_res;
        memwb_rd    <= exmem_rd;
        if (rst)
        begin
            memwb_mem_rd <= 1'b0;
            memwb_wr_reg <= 1'b0;
        end
        else
        begin
            memwb_mem_rd <= exmem_mem_rd;
            memwb_wr_reg <= exmem_wr_reg;
        end
    end

    assign wb_data = memwb_mem_rd ? memwb_mdata : memwb_res;

    // Back to decode
    assign bus.live_flags = flags_nxt;
    assign bus.ex_load_rd = idex_rd;
    assign bus.ex_is_load = idex_valid && idex_mem_rd;
    assign bus.wb_wr      = memwb_wr_reg;
    assign bus.wb_addr    = memwb_rd;
    assign bus.wb_data    = wb_data;

    // One memory access per cycle, decode never issues both
    a_rd_wr_excl: assert property (@(posedge clk) !(d_wr && d_rd));
    a_idle_after_rst: assert property (@(posedge clk) rst |=> (!d_wr && !d_rd));

endmodule

//--- design/fetch_decode.sv
/*
  Fetch and decode stages with branch and jump resolution in ID
  Every branch or jump squashes the one fetched slot after it, taken or not
  A load followed by an R-format user of its rd stalls one cycle
  A store right behind a load of its data register goes on without a stall
  Undefined load-immediate encodings issue as bubbles
*/
`include "zmips_consts.svh"

module fetch_decode (
    input  logic                clk,
    input  logic                rst,
    output logic [`ZM_XLEN-1:0] i_addr,
    input  logic [`ZM_XLEN-1:0] i_data,
    exe_bus_if.decode           bus
);
    import zmips_pkg::*;

    logic [`ZM_XLEN-1:0]  pc;
    logic [`ZM_XLEN-1:0]  pc_inc;
    logic [`ZM_XLEN-1:0]  pc_next;
    logic [`ZM_XLEN-1:0]  ifid_ir;
    logic [`ZM_XLEN-1:0]  ifid_pc4;     // Address after the instruction in ID
    logic                 ifid_valid;

    fmt_e                 fmt;
    cond_e                cond;
    logic [`ZM_RADDR-1:0] rs;
    logic [`ZM_RADDR-1:0] rt;
    logic [`ZM_XLEN-1:0]  imm_se;
    logic [`ZM_XLEN-1:0]  br_tgt;
    logic [`ZM_XLEN-1:0]  jmp_tgt;
    logic                 is_r;
    logic                 is_store;     // rt is only the store data
    logic                 is_limm;
    logic                 redirect;     // Branch or jump sitting in ID
    logic                 take;
    logic                 load_use;
    logic                 issue;

    // Fetch
    assign i_addr = pc;
    assign pc_inc = pc + `ZM_PC_STEP;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc <= `ZM_RESET_PC;
        end
        else if (!load_use)
        begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ifid_ir    <= '0;
            ifid_valid <= 1'b0;
        end
        else if (!load_use)
        begin
            ifid_ir    <= redirect ? '0 : i_data;   // Squash the slot after a branch
            ifid_valid <= !redirect;
            ifid_pc4   <= pc_inc;
        end
    end

    // Field split
    assign fmt     = fmt_e'(ifid_ir[31:30]);
    assign cond    = cond_e'(ifid_ir[27:26]);
    assign rs      = ifid_ir[25:21];
    assign rt      = ifid_ir[20:16];
    assign imm_se  = {{(`ZM_XLEN-`ZM_IMM_W){ifid_ir[`ZM_IMM_W-1]}}, ifid_ir[`ZM_IMM_W-1:0]};
    assign br_tgt  = ifid_pc4 + {imm_se[`ZM_XLEN-3:0], 2'b00};
    assign jmp_tgt = {ifid_ir[`ZM_JADDR_W-1:0], 2'b00};

    assign is_r     = (fmt == FMT_R);
    assign is_store = is_r && ifid_ir[28] && !ifid_ir[29];
    // Load immediate needs cc = 01 and the writeback bit
    assign is_limm = (fmt == FMT_LIMM) && (ifid_ir[27:26] == 2'b01) && ifid_ir[29];

    // Branch decision on flags forwarded from EX, bit 29 picks set or clear
    always_comb
    begin
        case (cond)
            COND_Z:  take = (bus.live_flags.z == ifid_ir[29]);
            COND_C:  take = (bus.live_flags.c == ifid_ir[29]);
            COND_N:  take = (bus.live_flags.n == ifid_ir[29]);
            default: take = 1'b1;   // Branch always
        endcase
    end

    assign redirect = ifid_valid && (fmt == FMT_BRANCH || fmt == FMT_JUMP);

    // Not taken refetches the squashed slot
    always_comb
    begin
        if (!redirect)
            pc_next = pc_inc;
        else if (fmt == FMT_JUMP)
            pc_next = jmp_tgt;
        else
            pc_next = take ? br_tgt : ifid_pc4;
    end

    // Load-use hazard against the instruction now in EX
    // Loaded store data is picked up later by execute on d_data_o
    assign load_use = ifid_valid && is_r && bus.ex_is_load &&
                      (bus.ex_load_rd == rs || (bus.ex_load_rd == rt && !is_store));

    // Branches and jumps end here and leave a bubble behind
    assign issue = ifid_valid && !load_use && (is_r || is_limm);

    regfile u_regfile (
        .clk     (clk),
        .rs_addr (rs),
        .rt_addr (rt),
        .rs_data (bus.rs_val),
        .rt_data (bus.rt_val),
        .wr      (bus.wb_wr),
        .wr_addr (bus.wb_addr),
        .wr_data (bus.wb_data)
    );

    // Issue to execute
    assign bus.rs        = rs;
    assign bus.rt        = rt;
    assign bus.rd        = is_limm ? '0 : ifid_ir[15:11];   // Load immediate targets r0
    assign bus.imm       = imm_se;
    assign bus.alu_op    = is_limm ? ALU_PASS_B : alu_op_e'({ifid_ir[26], ifid_ir[5:3]});
    assign bus.use_imm   = is_limm;
    assign bus.valid     = issue;
    assign bus.wr_reg    = issue && (is_limm || ifid_ir[29]);
    assign bus.mem_rd    = issue && is_r && ifid_ir[28] && ifid_ir[29];
    assign bus.mem_wr    = issue && is_r && ifid_ir[28] && !ifid_ir[29];
    assign bus.flag_en.z = issue && is_r && ifid_ir[2];
    assign bus.flag_en.c = issue && is_r && ifid_ir[1];
    assign bus.flag_en.n = issue && is_r && ifid_ir[0];

    // All targets are word multiples, so the PC never leaves word alignment
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

//--- design/regfile.sv
/*
  32 x 32 register file, two read ports and one write port
  No register is hard-wired to zero
  A read of the register written in the same cycle returns the new value
*/
`include "zmips_consts.svh"

module regfile (
    input  logic                 clk,
    input  logic [`ZM_RADDR-1:0] rs_addr,
    input  logic [`ZM_RADDR-1:0] rt_addr,
    output logic [`ZM_XLEN-1:0]  rs_data,
    output logic [`ZM_XLEN-1:0]  rt_data,
    input  logic                 wr,
    input  logic [`ZM_RADDR-1:0] wr_addr,
    input  logic [`ZM_XLEN-1:0]  wr_data
);
    logic [`ZM_XLEN-1:0] regs [`ZM_NREGS];

    always_ff @(posedge clk)
    begin
        if (wr)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-through bypass, WB and ID share the cycle
    always_comb
    begin
        rs_data = regs[rs_addr];
        rt_data = regs[rt_addr];
        if (wr && wr_addr == rs_addr)
            rs_data = wr_data;
        if (wr && wr_addr == rt_addr)
            rt_data = wr_data;
    end

endmodule

//--- design/zmips_top.sv
/*
  Core top level with separate instruction and data ports
  Both memories sit outside and must answer in the same cycle
  d_data_o is valid only while d_wr is high
*/
`include "zmips_consts.svh"

module zmips_top (
    input  logic                clk,
    input  logic                rst,        // Synchronous, active high
    output logic [`ZM_XLEN-1:0] i_addr,
    input  logic [`ZM_XLEN-1:0] i_data,
    output logic [`ZM_XLEN-1:0] d_addr,
    output logic [`ZM_XLEN-1:0] d_data_o,
    input  logic [`ZM_XLEN-1:0] d_data_i,
    output logic                d_wr,
    output logic                d_rd
);

    exe_bus_if bus ();   // ID/EX issue plus writeback return

    fetch_decode u_fetch_decode (
        .clk    (clk),
        .rst    (rst),
        .i_addr (i_addr),
        .i_data (i_data),
        .bus    (bus.decode)
    );

    exec_stage u_exec_stage (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus.execute),
        .d_addr   (d_addr),
        .d_data_o (d_data_o),
        .d_wr     (d_wr),
        .d_rd     (d_rd),
        .d_data_i (d_data_i)
    );

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_zmips -o tb_zmips_sim \
    || { echo "Build failed"; exit 1; }

./obj_dir/tb_zmips_sim > sim.log 2>&1 ; cat sim.log

grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; } \
    || grep -q "RESULT: PASS" sim.log || { echo "No result in log"; exit 1; }

//--- sim/tb_memory.sv
/*
  Instruction ROM with the test program and a data RAM model
  Both read combinationally, RAM writes on the rising edge
  64 words each, only address bits 7:2 are decoded
  RAM starts from $random with seed 86
*/
module tb_memory (
    input  logic        clk,
    input  logic [31:0] i_addr,
    output logic [31:0] i_data,
    input  logic [31:0] d_addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    input  logic        d_wr
);
    logic [31:0] rom [64];
    logic [31:0] ram [64];
    integer      seed;
    int          wp;        // Next ROM word to fill

    assign i_data = rom[i_addr[7:2]];
    assign rdata  = ram[d_addr[7:2]];

    always @(posedge clk)
    begin
        if (d_wr)
            ram[d_addr[7:2]] <= wdata;
    end

    // R-format word, fields in instruction order
    function automatic logic [31:0] r_word(input logic wb, input logic mem, input logic shift,
                                           input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] shamt,
                                           input logic [2:0] op, input logic [2:0] fl);
        r_word = {2'b00, wb, mem, 1'b0, shift, rs, rt, rd, shamt, op, fl};
    endfunction

    task automatic emit(input logic [31:0] w);
        rom[wp] = w;
        wp++;
    endtask

    task automatic alu_op(input logic [2:0] op, input logic [4:0] rd, input logic [4:0] rs,
                          input logic [4:0] rt);
        emit(r_word(1'b1, 1'b0, 1'b0, rs, rt, rd, 5'd0, op, 3'b000));
    endtask

    task automatic shift_op(input logic [2:0] op, input logic [4:0] rd, input logic [4:0] rs,
                            input logic [4:0] sh);
        emit(r_word(1'b1, 1'b0, 1'b1, rs, 5'd0, rd, sh, op, 3'b000));
    endtask

    task automatic store_op(input logic [4:0] ra, input logic [4:0] rt);
        emit(r_word(1'b0, 1'b1, 1'b0, ra, rt, 5'd0, 5'd0, 3'd6, 3'b000));   // Address = rs
    endtask

    task automatic load_op(input logic [4:0] rd, input logic [4:0] ra);
        emit(r_word(1'b1, 1'b1, 1'b0, ra, 5'd0, rd, 5'd0, 3'd6, 3'b000));
    endtask

    task automatic cmp_op(input logic [4:0] rs, input logic [4:0] rt);
        emit(r_word(1'b0, 1'b0, 1'b0, rs, rt, 5'd0, 5'd0, 3'd1, 3'b111));   // SUB, all flags
    endtask

    task automatic limm_op(input logic [25:0] imm);
        emit({2'b01, 1'b1, 1'b0, 2'b01, imm});
    endtask

    // Offset 1 skips the one poison store after the branch
    task automatic branch_op(input logic on_set, input logic [1:0] cond);
        emit({2'b10, on_set, 1'b0, cond, 26'd1});
    endtask

    task automatic jump_op(input logic [29:0] word);
        emit({2'b11, word});
    endtask

    initial
    begin
        seed = 86;
        for (int i = 0; i < 64; i++)
        begin
            ram[i] = $random(seed);
            rom[i] = 32'h0;     // NOP
        end
        wp = 0;
        limm_op(26'd5);            // 0  r0 = 5
        alu_op(3'd6, 5'd1, 5'd0, 5'd0);
        limm_op(26'd3);
        alu_op(3'd6, 5'd2, 5'd0, 5'd0);
        alu_op(3'd0, 5'd3, 5'd1, 5'd2);     // 4  add, chain of dependents
        alu_op(3'd1, 5'd4, 5'd3, 5'd1);
        alu_op(3'd4, 5'd5, 5'd4, 5'd3);
        shift_op(3'd0, 5'd6, 5'd5, 5'd4);   // sll 4
        alu_op(3'd5, 5'd7, 5'd6, 5'd2);     // nor
        shift_op(3'd2, 5'd8, 5'd7, 5'd2);   // sra 2
        shift_op(3'd1, 5'd9, 5'd7, 5'd28);  // 10 srl 28
        limm_op(26'h80);
        alu_op(3'd6, 5'd10, 5'd0, 5'd0);    // r10 store address
        for (int r = 3; r <= 9; r++)
            store_op(5'd10, 5'(r));          // 13..19
        limm_op(26'h10);                     // 20
        alu_op(3'd6, 5'd13, 5'd0, 5'd0);
        limm_op(26'h20);
        alu_op(3'd6, 5'd14, 5'd0, 5'd0);
        load_op(5'd15, 5'd13);               // 24 load then use at once
        alu_op(3'd0, 5'd16, 5'd15, 5'd1);
        store_op(5'd10, 5'd16);
        load_op(5'd17, 5'd14);               // load then store of the same register
        store_op(5'd10, 5'd17);
        limm_op(26'hF0);                     // 29 poison address
        alu_op(3'd6, 5'd12, 5'd0, 5'd0);
        cmp_op(5'd2, 5'd1);                  // 31 3-5 gives z0 c0 n1
        branch_op(1'b1, 2'd2);
        store_op(5'd12, 5'd1);
        store_op(5'd10, 5'd1);               // 34 marker
        branch_op(1'b0, 2'd0);
        store_op(5'd12, 5'd1);
        branch_op(1'b0, 2'd1);
        store_op(5'd12, 5'd1);
        cmp_op(5'd1, 5'd2);                  // 39 5-3 gives z0 c1 n0
        branch_op(1'b1, 2'd1);
        store_op(5'd12, 5'd1);
        branch_op(1'b0, 2'd2);
        store_op(5'd12, 5'd1);
        cmp_op(5'd1, 5'd1);                  // 44 zero result, z1 c1 n0
        branch_op(1'b1, 2'd0);
        store_op(5'd12, 5'd1);
        branch_op(1'b0, 2'd3);               // Always, bit 29 ignored
        store_op(5'd12, 5'd1);
        jump_op(30'd51);                     // 49
        store_op(5'd12, 5'd1);
        limm_op(26'h3FFFED4);                // 51 r0 = -300
        store_op(5'd10, 5'd0);
        jump_op(30'd53);                     // 53 halt loop
    end

endmodule

//--- sim/tb_zmips.sv
/*
  Testbench for zmips_top running the program held in tb_memory
  Every store is checked in order against a list built from the encoding rules
  Run ends when the fetch address reaches the halt loop, watchdog otherwise
*/
module tb_zmips;

    localparam int PROG_LEN  = 54;          // Words in the test program
    localparam int HALT_ADDR = 53 * 4;
    localparam int MAX_ST    = 16;

    logic        clk;
    logic        rst;
    logic [31:0] i_addr;
    logic [31:0] i_data;
    logic [31:0] d_addr;
    logic [31:0] d_data_o;
    logic [31:0] d_data_i;
    logic        d_wr;
    logic        d_rd;

    string       exp_name [MAX_ST];
    logic [31:0] exp_addr [MAX_ST];
    logic [31:0] exp_data [MAX_ST];
    int          n_exp;
    int          st_idx;                     // Next expected store
    logic [31:0] ram_copy [64];
    integer      seed;
    logic [31:0] r1, r2, r3, r4, r5, r6, r7, r8, r9;

    zmips_top dut (
        .clk      (clk),
        .rst      (rst),
        .i_addr   (i_addr),
        .i_data   (i_data),
        .d_addr   (d_addr),
        .d_data_o (d_data_o),
        .d_data_i (d_data_i),
        .d_wr     (d_wr),
        .d_rd     (d_rd)
    );

    tb_memory mem (
        .clk    (clk),
        .i_addr (i_addr),
        .i_data (i_data),
        .d_addr (d_addr),
        .wdata  (d_data_o),
        .rdata  (d_data_i),
        .d_wr   (d_wr)
    );

    task automatic add_store(input string name, input logic [31:0] addr,
                             input logic [31:0] data);
        exp_name[n_exp] = name;
        exp_addr[n_exp] = addr;
        exp_data[n_exp] = data;
        n_exp++;
    endtask

    // Expected stores, same seeded RAM contents as the model
    initial
    begin
        seed = 86;
        for (int i = 0; i < 64; i++)
            ram_copy[i] = $random(seed);
        n_exp = 0;
        r1 = 32'd5;
        r2 = 32'd3;
        r3 = r1 + r2;
        r4 = r3 - r1;
        r5 = r4 ^ r3;
        r6 = r5 << 4;
        r7 = ~(r6 | r2);
        r8 = $signed(r7) >>> 2;     // Sign fills from the top
        r9 = r7 >> 28;
        add_store("alu_add", 32'h80, r3);
        add_store("alu_sub", 32'h80, r4);
        add_store("alu_xor", 32'h80, r5);
        add_store("alu_sll", 32'h80, r6);
        add_store("alu_nor", 32'h80, r7);
        add_store("alu_sra", 32'h80, r8);
        add_store("alu_srl", 32'h80, r9);
        add_store("load_use", 32'h80, ram_copy[4] + r1);
        add_store("load_store", 32'h80, ram_copy[8]);
        add_store("branch_flags", 32'h80, r1);
        add_store("jump_limm", 32'h80, 32'hFFFFFED4);
    end

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (rst)
            st_idx <= 0;
        else if (d_wr)
            st_idx <= st_idx + 1;     // Step through the list
    end

    a_reset_idle: assert property (@(posedge clk) rst |=> (!d_wr && !d_rd && i_addr == 32'h0))
    else
    begin
        $display("Memory strobe or fetch address not idle after reset");
        $display("RESULT: FAIL");
        $fatal(1, "reset check");
    end

    a_store_count: assert property (@(posedge clk) disable iff (rst) d_wr |-> st_idx < n_exp)
    else
    begin
        $display("Store at %h beyond the expected list", $sampled(d_addr));
        $display("RESULT: FAIL");
        $fatal(1, "extra store");
    end

    // Poison stores land here as an address mismatch
    a_store_addr: assert property (@(posedge clk) disable iff (rst)
                                   (d_wr && st_idx < n_exp) |-> d_addr == exp_addr[st_idx])
    else
    begin
        $display("Mismatch %s address: expected %h actual %h", exp_name[$sampled(st_idx)],
                 exp_addr[$sampled(st_idx)], $sampled(d_addr));
        $display("RESULT: FAIL");
        $fatal(1, "store address");
    end

    a_store_data: assert property (@(posedge clk) disable iff (rst)
                                   (d_wr && st_idx < n_exp) |-> d_data_o == exp_data[st_idx])
    else
    begin
        $display("Mismatch %s data: expected %h actual %h", exp_name[$sampled(st_idx)],
                 exp_data[$sampled(st_idx)], $sampled(d_data_o));
        $display("RESULT: FAIL");
        $fatal(1, "store data");
    end

    // Watchdog, four cycles per program word
    initial
    begin
        #(PROG_LEN * 4 * 8);
        $display("Timeout, halt loop not reached");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog");
    end

    initial
    begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        while (i_addr != HALT_ADDR)
            @(posedge clk);
        repeat (6) @(posedge clk);    // Drain the store still in flight
        if (st_idx == n_exp)
        begin
            $display("RESULT: PASS");
            $finish;
        end
        else
        begin
            $display("Only %0d of %0d expected stores arrived", st_idx, n_exp);
            $display("RESULT: FAIL");
            $fatal(1, "missing stores");
        end
    end

endmodule
